/* rtl/cache_bus_pkg.sv */
`default_nettype none

package cache_bus_pkg;

  ////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////

  // Zero byte_en is a read, anything else a write
  typedef struct packed {
    cache_geom_pkg::word_addr_t                addr;
    logic [cache_geom_pkg::WORD_BITS-1:0]      data;
    logic [3:0]                                byte_en;
  } cpu_req_t;

  typedef struct packed {
    logic [cache_geom_pkg::WORD_BITS-1:0] data;
  } cpu_resp_t;

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  // One full beat per request, data ignored on reads
  typedef struct packed {
    logic [cache_geom_pkg::BEAT_ADDR_BITS-1:0] addr;
    logic                                      write;
    logic [cache_geom_pkg::BEAT_BITS-1:0]      data;
  } mem_req_t;

  // Read beats come back in request order
  typedef struct packed {
    logic [cache_geom_pkg::BEAT_BITS-1:0] data;
  } mem_resp_t;

endpackage

`default_nettype wire

/* rtl/cache_ctrl.sv */
`default_nettype none

module cache_ctrl (
  input  logic                                 clk,
  input  logic                                 reset,
  // Request queue
  input  logic                                 req_valid,
  output logic                                 req_ready,
  input  cache_bus_pkg::cpu_req_t              req,
  // CPU response, valid only
  output logic                                 cpu_resp_valid,
  output cache_bus_pkg::cpu_resp_t             cpu_resp,
  // Memory
  output logic                                 mem_req_valid,
  input  logic                                 mem_req_ready,
  output cache_bus_pkg::mem_req_t              mem_req,
  input  logic                                 mem_resp_valid,
  input  cache_bus_pkg::mem_resp_t             mem_resp,
  // Store commands and results
  output cache_geom_pkg::index_t               rd_index,
  input  cache_geom_pkg::tag_t                 tag_out,
  input  logic                                 valid_out,
  input  logic                                 dirty_out,
  input  logic [cache_geom_pkg::LINE_BITS-1:0] line_out,
  output logic                                 word_we,
  output cache_geom_pkg::word_addr_t           word_addr,
  output logic [cache_geom_pkg::WORD_BITS-1:0] word_data,
  output logic [3:0]                           word_byte_en,
  output logic                                 beat_we,
  output cache_geom_pkg::index_t               beat_index,
  output logic [1:0]                           beat_sel,
  output logic [cache_geom_pkg::BEAT_BITS-1:0] beat_data,
  output logic                                 tag_we,
  output cache_geom_pkg::index_t               tag_index,
  output cache_geom_pkg::tag_t                 tag_in
);
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITE_BACK,
    ST_REFILL,
    ST_RESPOND
  } state_t;

  localparam logic [2:0] LAST_BEAT = 3'(BEATS_PER_LINE - 1);

  state_t     state;
  cpu_req_t   cur_req;
  logic [2:0] sent_cnt;
  logic [2:0] recv_cnt;
  logic       hit;
  logic       is_write;
  int         word_slot;

  assign req_ready = (state == ST_IDLE);
  assign hit = valid_out && (tag_out == cur_req.addr.tag);
  assign is_write = |cur_req.byte_en;
  assign word_slot = int'(cur_req.addr.beat_sel) * WORDS_PER_BEAT
                   + int'(cur_req.addr.word_sel);

  // While idle, look ahead at the queue head so the tag is ready in lookup
  assign rd_index = (state == ST_IDLE) ? req.addr.index : cur_req.addr.index;

  ////////////////////////////////////////
  // Store commands
  ////////////////////////////////////////

  assign word_we = (state == ST_LOOKUP) && hit && is_write;
  assign word_addr = cur_req.addr;
  assign word_data = cur_req.data;
  assign word_byte_en = cur_req.byte_en;

  // Returning beats go straight into the line
  assign beat_we = (state == ST_REFILL) && mem_resp_valid;
  assign beat_index = cur_req.addr.index;
  assign beat_sel = recv_cnt[1:0];
  assign beat_data = mem_resp.data;

  assign tag_we = beat_we && (recv_cnt == LAST_BEAT);
  assign tag_index = cur_req.addr.index;
  assign tag_in = cur_req.addr.tag;

  ////////////////////////////////////////
  // Memory requests
  ////////////////////////////////////////

  always_comb begin
    mem_req_valid = 1'b0;
    mem_req.write = 1'b0;
    mem_req.addr  = {cur_req.addr.tag, cur_req.addr.index, sent_cnt[1:0]};
    mem_req.data  = '0;
    if (state == ST_WRITE_BACK) begin
      // Victim tag and data stay put, nothing writes the line yet
      mem_req_valid = 1'b1;
      mem_req.write = 1'b1;
      mem_req.addr  = {tag_out, cur_req.addr.index, sent_cnt[1:0]};
      mem_req.data  = line_out[sent_cnt[1:0]*BEAT_BITS +: BEAT_BITS];
    end else if (state == ST_REFILL) begin
      mem_req_valid = (sent_cnt != 3'(BEATS_PER_LINE));
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= ST_IDLE;
      sent_cnt       <= '0;
      recv_cnt       <= '0;
      cpu_resp_valid <= 1'b0;
    end else begin
      cpu_resp_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req_valid)
            state <= ST_LOOKUP;
        end
        ST_LOOKUP: begin
          sent_cnt <= '0;
          recv_cnt <= '0;
          if (hit) begin
            cpu_resp_valid <= !is_write;
            state          <= ST_IDLE;
          end else if (valid_out && dirty_out) begin
            state <= ST_WRITE_BACK;
          end else begin
            state <= ST_REFILL;
          end
        end
        ST_WRITE_BACK: begin
          if (mem_req_ready) begin
            if (sent_cnt == LAST_BEAT) begin
              sent_cnt <= '0;
              state    <= ST_REFILL;
            end else begin
              sent_cnt <= sent_cnt + 1'b1;
            end
          end
        end
        ST_REFILL: begin
          // Reads overlap, sends and returns counted apart
          if (mem_req_valid && mem_req_ready)
            sent_cnt <= sent_cnt + 1'b1;
          if (mem_resp_valid) begin
            recv_cnt <= recv_cnt + 1'b1;
            if (recv_cnt == LAST_BEAT)
              state <= ST_RESPOND;
          end
        end
        // One cycle so the store read sees the refilled line
        ST_RESPOND: state <= ST_LOOKUP;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready)
      cur_req <= req;
    if (state == ST_LOOKUP)
      cpu_resp.data <= line_out[word_slot*WORD_BITS +: WORD_BITS];
  end

endmodule

`default_nettype wire

/* rtl/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int WORD_BITS = 32;
  localparam int BEAT_BITS = 128;
  localparam int BEATS_PER_LINE = 4;
  localparam int WORDS_PER_BEAT = BEAT_BITS / WORD_BITS;
  localparam int LINE_BITS = BEAT_BITS * BEATS_PER_LINE;

  // 8 lines of 64 bytes, direct mapped
  localparam int LINES = 8;
  localparam int INDEX_BITS = $clog2(LINES);

  localparam int WORD_ADDR_BITS = 30;
  localparam int BEAT_ADDR_BITS = WORD_ADDR_BITS - $clog2(WORDS_PER_BEAT);
  // Beat select and word select take 2 bits each
  localparam int TAG_BITS = WORD_ADDR_BITS - INDEX_BITS - 4;

  localparam int QUEUE_DEPTH = 4;

  ////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////

  typedef logic [TAG_BITS-1:0] tag_t;
  typedef logic [INDEX_BITS-1:0] index_t;

  // Word address, msb first
  typedef struct packed {
    tag_t       tag;
    index_t     index;
    logic [1:0] beat_sel;
    logic [1:0] word_sel;
  } word_addr_t;

endpackage

`default_nettype wire

/* rtl/cache_store.sv */
`default_nettype none

module cache_store (
  input  logic                                 clk,
  input  logic                                 reset,
  // Read port, one cycle latency
  input  cache_geom_pkg::index_t               rd_index,
  output cache_geom_pkg::tag_t                 tag_out,
  output logic                                 valid_out,
  output logic                                 dirty_out,
  output logic [cache_geom_pkg::LINE_BITS-1:0] line_out,
  // CPU word write
  input  logic                                 word_we,
  input  cache_geom_pkg::word_addr_t           word_addr,
  input  logic [cache_geom_pkg::WORD_BITS-1:0] word_data,
  input  logic [3:0]                           word_byte_en,
  // Refill beat write
  input  logic                                 beat_we,
  input  cache_geom_pkg::index_t               beat_index,
  input  logic [1:0]                           beat_sel,
  input  logic [cache_geom_pkg::BEAT_BITS-1:0] beat_data,
  // Tag install
  input  logic                                 tag_we,
  input  cache_geom_pkg::index_t               tag_index,
  input  cache_geom_pkg::tag_t                 tag_in
);
  import cache_geom_pkg::*;

  tag_t                 tags  [LINES];
  logic [LINE_BITS-1:0] lines [LINES];
  logic [LINES-1:0]     valid;
  logic [LINES-1:0]     dirty;
  int                   word_slot;

  // Word position inside the line
  assign word_slot = int'(word_addr.beat_sel) * WORDS_PER_BEAT + int'(word_addr.word_sel);

  ////////////////////////////////////////
  // Line state
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      // New line lands clean
      if (tag_we) begin
        valid[tag_index] <= 1'b1;
        dirty[tag_index] <= 1'b0;
      end
      if (word_we)
        dirty[word_addr.index] <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Tags and data
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tag_we)
      tags[tag_index] <= tag_in;
    if (beat_we)
      lines[beat_index][beat_sel*BEAT_BITS +: BEAT_BITS] <= beat_data;
    if (word_we) begin
      for (int b = 0; b < WORD_BITS / 8; b++) begin
        if (word_byte_en[b])
          lines[word_addr.index][word_slot*WORD_BITS + b*8 +: 8] <= word_data[b*8 +: 8];
      end
    end
  end

  // Registered read, returns the contents from before this edge's writes
  always_ff @(posedge clk) begin
    tag_out   <= tags[rd_index];
    valid_out <= valid[rd_index];
    dirty_out <= dirty[rd_index];
    line_out  <= lines[rd_index];
  end

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
`default_nettype none

module dcache_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cpu_req_valid,
  output logic                     cpu_req_ready,
  input  cache_bus_pkg::cpu_req_t  cpu_req,
  output logic                     cpu_resp_valid,
  output cache_bus_pkg::cpu_resp_t cpu_resp,
  output logic                     mem_req_valid,
  input  logic                     mem_req_ready,
  output cache_bus_pkg::mem_req_t  mem_req,
  input  logic                     mem_resp_valid,
  input  cache_bus_pkg::mem_resp_t mem_resp
);
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;

  // Queue to controller
  logic     q_valid;
  logic     q_ready;
  cpu_req_t q_req;

  // Controller to store
  index_t               rd_index;
  tag_t                 tag_out;
  logic                 valid_out;
  logic                 dirty_out;
  logic [LINE_BITS-1:0] line_out;
  logic                 word_we;
  word_addr_t           word_addr;
  logic [WORD_BITS-1:0] word_data;
  logic [3:0]           word_byte_en;
  logic                 beat_we;
  index_t               beat_index;
  logic [1:0]           beat_sel;
  logic [BEAT_BITS-1:0] beat_data;
  logic                 tag_we;
  index_t               tag_index;
  tag_t                 tag_in;

  req_queue #(
    .payload_t (cpu_req_t)
  ) u_req_queue (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (cpu_req_valid),
    .in_ready  (cpu_req_ready),
    .in_data   (cpu_req),
    .out_valid (q_valid),
    .out_ready (q_ready),
    .out_data  (q_req)
  );

  cache_ctrl u_cache_ctrl (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (q_valid),
    .req_ready      (q_ready),
    .req            (q_req),
    .cpu_resp_valid (cpu_resp_valid),
    .cpu_resp       (cpu_resp),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp),
    .rd_index       (rd_index),
    .tag_out        (tag_out),
    .valid_out      (valid_out),
    .dirty_out      (dirty_out),
    .line_out       (line_out),
    .word_we        (word_we),
    .word_addr      (word_addr),
    .word_data      (word_data),
    .word_byte_en   (word_byte_en),
    .beat_we        (beat_we),
    .beat_index     (beat_index),
    .beat_sel       (beat_sel),
    .beat_data      (beat_data),
    .tag_we         (tag_we),
    .tag_index      (tag_index),
    .tag_in         (tag_in)
  );

  cache_store u_cache_store (
    .clk          (clk),
    .reset        (reset),
    .rd_index     (rd_index),
    .tag_out      (tag_out),
    .valid_out    (valid_out),
    .dirty_out    (dirty_out),
    .line_out     (line_out),
    .word_we      (word_we),
    .word_addr    (word_addr),
    .word_data    (word_data),
    .word_byte_en (word_byte_en),
    .beat_we      (beat_we),
    .beat_index   (beat_index),
    .beat_sel     (beat_sel),
    .beat_data    (beat_data),
    .tag_we       (tag_we),
    .tag_index    (tag_index),
    .tag_in       (tag_in)
  );

endmodule

`default_nettype wire

/* rtl/req_queue.sv */
`default_nettype none

module req_queue #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);
  import cache_geom_pkg::*;

  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
  localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

  payload_t            slots [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic [CNT_BITS-1:0] count_next;
  logic                push;
  logic                pop;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(QUEUE_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_data = slots[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop)
      count_next = count + 1'b1;
    else if (pop && !push)
      count_next = count - 1'b1;
  end

  // Ready is registered, low while full
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      count    <= count_next;
      in_ready <= (count_next != CNT_BITS'(QUEUE_DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      slots[wr_ptr] <= in_data;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the data cache testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module dcache_tb -o dcache_sim

./obj_dir/dcache_sim

/* tb/dcache_tb.sv */
`default_nettype none

module dcache_tb;
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;

  logic      clk = 1'b0;
  logic      reset;
  logic      cpu_req_valid;
  logic      cpu_req_ready;
  cpu_req_t  cpu_req;
  logic      cpu_resp_valid;
  cpu_resp_t cpu_resp;
  logic      mem_req_valid;
  logic      mem_req_ready;
  mem_req_t  mem_req;
  logic      mem_resp_valid;
  mem_resp_t mem_resp;
  int        mem_req_count;

  logic [WORD_BITS-1:0] shadow [logic [WORD_ADDR_BITS-1:0]];
  logic [WORD_BITS-1:0] expected [$];
  int                   issued = 0;
  int                   cycles = 0;
  int                   stall_cycles = 0;

  always #5 clk = ~clk;

  dcache_top u_dcache_top (
    .clk            (clk),
    .reset          (reset),
    .cpu_req_valid  (cpu_req_valid),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_req        (cpu_req),
    .cpu_resp_valid (cpu_resp_valid),
    .cpu_resp       (cpu_resp),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp)
  );

  mem_model u_mem_model (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (mem_req_valid),
    .req_ready  (mem_req_ready),
    .req        (mem_req),
    .resp_valid (mem_resp_valid),
    .resp       (mem_resp),
    .req_count  (mem_req_count)
  );

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  function automatic logic [WORD_BITS-1:0] initial_word(input logic [WORD_ADDR_BITS-1:0] wa);
    return ({2'b00, wa} * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  // Applies the request to the shadow words, returns the word after it
  function automatic logic [WORD_BITS-1:0] reference_access(input cpu_req_t r);
    logic [WORD_BITS-1:0] word;
    word = shadow.exists(r.addr) ? shadow[r.addr] : initial_word(r.addr);
    for (int b = 0; b < 4; b++) begin
      if (r.byte_en[b])
        word[b*8 +: 8] = r.data[b*8 +: 8];
    end
    shadow[r.addr] = word;
    return word;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  always @(negedge clk) begin
    if (reset) begin
      check_value("cpu_req_ready", {31'b0, cpu_req_ready}, 32'd0);
    end else begin
      // Quiet outputs until the first request
      if (issued == 0) begin
        check_value("cpu_resp_valid", {31'b0, cpu_resp_valid}, 32'd0);
        check_value("mem_req_valid", {31'b0, mem_req_valid}, 32'd0);
      end
      if (!cpu_req_ready)
        stall_cycles++;
      if (cpu_resp_valid) begin
        if (expected.size() == 0)
          fail_run("a read response arrived with no read outstanding");
        else
          check_value("cpu_resp.data", cpu_resp.data, expected.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > 40 * issued + 200)
      fail_run("timeout, the cache stopped making progress");
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  function automatic word_addr_t make_addr(input int tag, input int index, input int beat,
                                           input int word);
    word_addr_t a;
    a.tag = TAG_BITS'(tag);
    a.index = INDEX_BITS'(index);
    a.beat_sel = 2'(beat);
    a.word_sel = 2'(word);
    return a;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Called just after a rising edge, returns one edge after the handshake
  task automatic send_request(input cpu_req_t r);
    logic [WORD_BITS-1:0] exp;
    cpu_req_valid = 1'b1;
    cpu_req = r;
    issued++;
    while (!cpu_req_ready)
      idle_cycles(1);
    exp = reference_access(r);
    if (r.byte_en == 4'b0000)
      expected.push_back(exp);
    idle_cycles(1);
    cpu_req_valid = 1'b0;
  endtask

  task automatic read_word(input word_addr_t a);
    cpu_req_t r;
    r.addr = a;
    r.data = '0;
    r.byte_en = 4'b0000;
    send_request(r);
  endtask

  task automatic write_word(input word_addr_t a, input logic [31:0] data, input logic [3:0] be);
    cpu_req_t r;
    r.addr = a;
    r.data = data;
    r.byte_en = be;
    send_request(r);
  endtask

  task automatic random_request();
    cpu_req_t r;
    r.addr = make_addr(int'($urandom_range(3)), ($urandom_range(1) == 0) ? 2 : 6,
                       int'($urandom_range(3)), int'($urandom_range(3)));
    r.data = $urandom();
    r.byte_en = ($urandom_range(1) == 0) ? 4'b0000 : 4'($urandom_range(15, 1));
    send_request(r);
    if ($urandom_range(7) == 0)
      idle_cycles(1);
  endtask

  // Bounded by a full queue of dirty misses
  task automatic drain_reads();
    int waited;
    waited = 0;
    while (expected.size() != 0 && waited < 40 * (QUEUE_DEPTH + 1)) begin
      @(negedge clk);
      waited++;
    end
    if (expected.size() != 0)
      fail_run("reads were still waiting for a response after the drain limit");
    idle_cycles(1);
  endtask

  initial begin
    int reqs_before;
    int stalls_before;
    void'($urandom(84010));
    reset = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    idle_cycles(5);

    // Cold miss, then a hit in the same line
    read_word(make_addr(3, 1, 2, 1));
    drain_reads();
    check_value("mem_req_count", mem_req_count, 32'd4);
    reqs_before = mem_req_count;
    read_word(make_addr(3, 1, 0, 3));
    drain_reads();
    check_value("mem_req_count", mem_req_count, reqs_before);

    // Byte merges on a cached word
    write_word(make_addr(3, 1, 2, 1), 32'hdead_beef, 4'b0101);
    write_word(make_addr(3, 1, 2, 1), 32'h1234_5678, 4'b1000);
    read_word(make_addr(3, 1, 2, 1));
    drain_reads();

    // Dirty victim goes back to memory and returns on the next miss
    write_word(make_addr(7, 5, 1, 2), 32'hcafe_f00d, 4'b1111);
    read_word(make_addr(7, 5, 1, 2));
    drain_reads();
    reqs_before = mem_req_count;
    read_word(make_addr(9, 5, 3, 0));
    drain_reads();
    check_value("mem_req_count", mem_req_count - reqs_before, 32'd8);
    read_word(make_addr(7, 5, 1, 2));
    drain_reads();

    for (int i = 0; i < 300; i++)
      random_request();
    drain_reads();

    // Back to back misses fill the queue
    stalls_before = stall_cycles;
    for (int i = 0; i < 16; i++) begin
      if (i % 2 == 0)
        read_word(make_addr(10 + i % 3, 4, i % 4, (i * 3) % 4));
      else
        write_word(make_addr(10 + i % 3, 4, i % 4, (i * 3) % 4), $urandom(), 4'b0011);
    end
    drain_reads();
    if (stall_cycles == stalls_before)
      fail_run("cpu_req_ready never dropped during the request burst");

    idle_cycles(20);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/mem_model.sv */
`default_nettype none

module mem_model (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  cache_bus_pkg::mem_req_t  req,
  output logic                     resp_valid,
  output cache_bus_pkg::mem_resp_t resp,
  output int                       req_count
);
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;

  localparam int READ_DELAY = 3;

  logic [BEAT_BITS-1:0] store [logic [BEAT_ADDR_BITS-1:0]];
  logic [BEAT_BITS-1:0] pend_data [$];
  int                   pend_due [$];
  int                   now;

  // Odd multiplier, so every address bit changes the word
  function automatic logic [WORD_BITS-1:0] pattern_word(input logic [WORD_ADDR_BITS-1:0] wa);
    return ({2'b00, wa} * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [BEAT_BITS-1:0] read_beat(input logic [BEAT_ADDR_BITS-1:0] ba);
    logic [BEAT_BITS-1:0] beat;
    if (store.exists(ba))
      return store[ba];
    for (int i = 0; i < WORDS_PER_BEAT; i++)
      beat[i*WORD_BITS +: WORD_BITS] = pattern_word({ba, 2'(i)});
    return beat;
  endfunction

  // Handshake taken mid cycle, where both sides are settled
  initial begin
    req_count = 0;
    forever begin
      @(negedge clk);
      if (!reset && req_valid && req_ready) begin
        req_count++;
        if (req.write) begin
          store[req.addr] = req.data;
        end else begin
          pend_data.push_back(read_beat(req.addr));
          pend_due.push_back(now + READ_DELAY);
        end
      end
    end
  end

  initial begin
    req_ready = 1'b0;
    resp_valid = 1'b0;
    resp = '0;
    now = 0;
    forever begin
      @(posedge clk);
      now++;
      #1;
      resp_valid = 1'b0;
      if (reset) begin
        req_ready = 1'b0;
      end else begin
        // Ready low about one cycle in four
        req_ready = ($urandom_range(3) != 0);
        if (pend_due.size() != 0 && pend_due[0] == now) begin
          resp_valid = 1'b1;
          resp.data = pend_data.pop_front();
          void'(pend_due.pop_front());
        end
      end
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/cache_geom_pkg.sv
rtl/cache_bus_pkg.sv
rtl/req_queue.sv
rtl/cache_store.sv
rtl/cache_ctrl.sv
rtl/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv
